// ==== source/adc_pkg.sv ====
package adc_pkg;

        // converter result and input channel
        typedef logic [11:0] adc_sample_t;
        typedef logic [4:0]  adc_channel_t;

        // apb bus widths
        typedef logic [7:0]  apb_addr_t;               // byte address
        typedef logic [31:0] apb_data_t;

        // register map, byte offsets
        localparam apb_addr_t REG_CTRL   = 8'h00;      // enable, filter_en, channel
        localparam apb_addr_t REG_STATUS = 8'h04;      // sample_ready, overrun
        localparam apb_addr_t REG_DATA   = 8'h08;      // sample and its channel
        localparam apb_addr_t REG_COUNT  = 8'h0C;      // completed conversions

        // CTRL field positions
        localparam int CTRL_ENABLE_BIT    = 0;
        localparam int CTRL_FILTER_EN_BIT = 1;
        localparam int CTRL_CHANNEL_LSB   = 4;

        // STATUS field positions
        localparam int STATUS_READY_BIT   = 0;
        localparam int STATUS_OVERRUN_BIT = 1;

        // one command in flight at a time
        typedef enum logic [1:0]
        {
                SEQ_IDLE,                              // waiting for a trigger
                SEQ_COMMAND,                           // cmd_valid high
                SEQ_WAIT_RESP                          // command taken, result pending
        } seq_state_t;

endpackage

// ==== source/adc_sequencer.sv ====
`timescale 1ns/1ns

module adc_sequencer
(
        input  logic                  sys_clk,
        input  logic                  reset,
        input  logic                  enable,
        input  adc_pkg::adc_channel_t channel,
        input  logic                  sync_trigger,
        input  logic                  cmd_ready,
        input  logic                  rsp_valid,
        output logic                  cmd_valid,
        output adc_pkg::adc_channel_t cmd_channel
);

        import adc_pkg::*;

        seq_state_t state;
        seq_state_t state_next;
        logic       start;

        // a trigger only counts when idle and enabled
        assign start = (state == SEQ_IDLE) && enable && sync_trigger;

        always_comb
        begin
                state_next = state;
                case (state)
                        SEQ_IDLE:
                        begin
                                if (start)
                                        state_next = SEQ_COMMAND;
                        end
                        SEQ_COMMAND:
                        begin
                                if (cmd_ready)             // handshake completes
                                        state_next = SEQ_WAIT_RESP;
                        end
                        SEQ_WAIT_RESP:
                        begin
                                if (rsp_valid)             // single response beat
                                        state_next = SEQ_IDLE;
                        end
                        default:
                        begin
                                state_next = SEQ_IDLE;
                        end
                endcase
        end

        always_ff @(posedge sys_clk)
        begin
                if (reset)
                        state <= SEQ_IDLE;
                else
                        state <= state_next;
        end

        // channel frozen at trigger time, later CTRL writes wait for the next one
        always_ff @(posedge sys_clk)
        begin
                if (start)
                        cmd_channel <= channel;
        end

        // held until cmd_ready is seen
        assign cmd_valid = (state == SEQ_COMMAND);

endmodule

// ==== source/adc_average_filter.sv ====
`timescale 1ns/1ns

module adc_average_filter
#(
        parameter int FILTER_DEPTH = 6
)
(
        input  logic                  sys_clk,
        input  logic                  reset,
        input  logic                  filter_en,
        input  logic                  filter_clear,
        input  logic                  rsp_valid,
        input  adc_pkg::adc_channel_t rsp_channel,
        input  adc_pkg::adc_sample_t  rsp_data,
        output logic                  sample_valid,
        output adc_pkg::adc_sample_t  sample_data,
        output adc_pkg::adc_channel_t sample_channel
);

        import adc_pkg::*;

        localparam int SAMPLE_W = $bits(adc_sample_t);
        localparam int SUM_W    = SAMPLE_W + $clog2(FILTER_DEPTH);   // holds depth * max sample

        adc_sample_t        hist [FILTER_DEPTH];      // hist[0] is the newest
        logic [SUM_W-1:0]   sum_q;                    // running sum of hist
        logic [SUM_W-1:0]   sum_base;
        logic [SUM_W-1:0]   sum_oldest;
        logic [SUM_W-1:0]   sum_next;
        logic [SUM_W-1:0]   avg;

        // a clear in the same cycle as a response starts from an empty history
        assign sum_base   = filter_clear ? '0 : sum_q;
        assign sum_oldest = filter_clear ? '0 : SUM_W'(hist[FILTER_DEPTH-1]);

        // drop the oldest sample, add the current one
        assign sum_next = sum_base - sum_oldest + SUM_W'(rsp_data);
        assign avg      = sum_next / SUM_W'(FILTER_DEPTH);     // truncated mean

        always_ff @(posedge sys_clk)
        begin
                if (reset)
                begin
                        for (int i = 0; i < FILTER_DEPTH; i++)
                                hist[i] <= '0;
                        sum_q <= '0;
                end
                else
                begin
                        if (filter_clear)
                        begin
                                for (int i = 0; i < FILTER_DEPTH; i++)
                                        hist[i] <= '0;
                                sum_q <= '0;
                        end
                        // history fills in bypass mode too
                        if (rsp_valid)
                        begin
                                hist[0] <= rsp_data;
                                for (int i = 1; i < FILTER_DEPTH; i++)
                                        hist[i] <= filter_clear ? '0 : hist[i-1];
                                sum_q <= sum_next;
                        end
                end
        end

        always_ff @(posedge sys_clk)
        begin
                if (reset)
                        sample_valid <= 1'b0;
                else
                        sample_valid <= rsp_valid;            // one cycle behind the response
        end

        always_ff @(posedge sys_clk)
        begin
                if (rsp_valid)
                begin
                        sample_data    <= filter_en ? avg[SAMPLE_W-1:0] : rsp_data;
                        sample_channel <= rsp_channel;
                end
        end

endmodule

// ==== source/adc_apb_regs.sv ====
`timescale 1ns/1ns

module adc_apb_regs
(
        input  logic                  sys_clk,
        input  logic                  reset,
        input  logic                  psel,
        input  logic                  penable,
        input  logic                  pwrite,
        input  adc_pkg::apb_addr_t    paddr,
        input  adc_pkg::apb_data_t    pwdata,
        output adc_pkg::apb_data_t    prdata,
        output logic                  pready,
        output logic                  pslverr,
        input  logic                  sample_valid,
        input  adc_pkg::adc_sample_t  sample_data,
        input  adc_pkg::adc_channel_t sample_channel,
        output logic                  enable,
        output logic                  filter_en,
        output logic                  filter_clear,
        output adc_pkg::adc_channel_t channel
);

        import adc_pkg::*;

        logic         access;
        logic         hit_ctrl;
        logic         hit_status;
        logic         hit_data;
        logic         hit_count;
        logic         mapped;
        logic         read_only;
        logic         wr_ctrl;
        logic         rd_status;
        logic         rd_data;

        logic         sample_ready;
        logic         overrun;
        adc_sample_t  data_sample;
        adc_channel_t data_channel;
        logic [15:0]  conv_count;

        // access phase of a zero wait state transfer
        assign access = psel && penable;
        assign pready = 1'b1;

        assign hit_ctrl   = (paddr == REG_CTRL);
        assign hit_status = (paddr == REG_STATUS);
        assign hit_data   = (paddr == REG_DATA);
        assign hit_count  = (paddr == REG_COUNT);
        assign mapped     = hit_ctrl || hit_status || hit_data || hit_count;
        assign read_only  = hit_status || hit_data || hit_count;

        assign pslverr = access && (!mapped || (pwrite && read_only));

        assign wr_ctrl   = access && pwrite && hit_ctrl;
        assign rd_status = access && !pwrite && hit_status;
        assign rd_data   = access && !pwrite && hit_data;

        always_ff @(posedge sys_clk)
        begin
                if (reset)
                begin
                        enable       <= 1'b0;
                        filter_en    <= 1'b0;
                        channel      <= '0;
                        filter_clear <= 1'b0;
                end
                else
                begin
                        filter_clear <= wr_ctrl;               // one cycle per CTRL write
                        if (wr_ctrl)
                        begin
                                enable    <= pwdata[CTRL_ENABLE_BIT];
                                filter_en <= pwdata[CTRL_FILTER_EN_BIT];
                                channel   <= pwdata[CTRL_CHANNEL_LSB +: $bits(adc_channel_t)];
                        end
                end
        end

        always_ff @(posedge sys_clk)
        begin
                if (reset)
                begin
                        sample_ready <= 1'b0;
                        overrun      <= 1'b0;
                        data_sample  <= '0;
                        data_channel <= '0;
                        conv_count   <= '0;
                end
                else
                begin
                        if (rd_data)
                                sample_ready <= 1'b0;
                        if (rd_status)
                                overrun <= 1'b0;
                        // a new result wins over a clear in the same cycle
                        if (sample_valid)
                        begin
                                sample_ready <= 1'b1;
                                data_sample  <= sample_data;
                                data_channel <= sample_channel;
                                conv_count   <= conv_count + 16'd1;    // wraps
                                if (sample_ready && !rd_data)           // previous result unread
                                        overrun <= 1'b1;
                        end
                end
        end

        always_comb
        begin
                prdata = '0;
                if (hit_ctrl)
                begin
                        prdata[CTRL_ENABLE_BIT]    = enable;
                        prdata[CTRL_FILTER_EN_BIT] = filter_en;
                        prdata[CTRL_CHANNEL_LSB +: $bits(adc_channel_t)] = channel;
                end
                else if (hit_status)
                begin
                        prdata[STATUS_READY_BIT]   = sample_ready;
                        prdata[STATUS_OVERRUN_BIT] = overrun;
                end
                else if (hit_data)
                        prdata = {11'd0, data_channel, 4'd0, data_sample};
                else if (hit_count)
                        prdata = {16'd0, conv_count};
        end

endmodule

// ==== source/adc_subsystem.sv ====
`timescale 1ns/1ns

module adc_subsystem
#(
        parameter int FILTER_DEPTH = 6
)
(
        input  logic                  sys_clk,
        input  logic                  reset,
        input  logic                  psel,
        input  logic                  penable,
        input  logic                  pwrite,
        input  adc_pkg::apb_addr_t    paddr,
        input  adc_pkg::apb_data_t    pwdata,
        output adc_pkg::apb_data_t    prdata,
        output logic                  pready,
        output logic                  pslverr,
        input  logic                  sync_trigger,
        output logic                  cmd_valid,
        output adc_pkg::adc_channel_t cmd_channel,
        input  logic                  cmd_ready,
        input  logic                  rsp_valid,
        input  adc_pkg::adc_channel_t rsp_channel,
        input  adc_pkg::adc_sample_t  rsp_data
);

        import adc_pkg::*;

        // control from the register block
        logic         enable;
        logic         filter_en;
        logic         filter_clear;
        adc_channel_t channel;

        // filtered result into the register block
        logic         sample_valid;
        adc_sample_t  sample_data;
        adc_channel_t sample_channel;

        adc_sequencer adc_sequencer_inst (
                .sys_clk      (sys_clk),
                .reset        (reset),
                .enable       (enable),
                .channel      (channel),
                .sync_trigger (sync_trigger),
                .cmd_ready    (cmd_ready),
                .rsp_valid    (rsp_valid),
                .cmd_valid    (cmd_valid),
                .cmd_channel  (cmd_channel)
        );

        adc_average_filter #(
                .FILTER_DEPTH (FILTER_DEPTH)
        ) adc_average_filter_inst (
                .sys_clk        (sys_clk),
                .reset          (reset),
                .filter_en      (filter_en),
                .filter_clear   (filter_clear),
                .rsp_valid      (rsp_valid),
                .rsp_channel    (rsp_channel),
                .rsp_data       (rsp_data),
                .sample_valid   (sample_valid),
                .sample_data    (sample_data),
                .sample_channel (sample_channel)
        );

        adc_apb_regs adc_apb_regs_inst (
                .sys_clk        (sys_clk),
                .reset          (reset),
                .psel           (psel),
                .penable        (penable),
                .pwrite         (pwrite),
                .paddr          (paddr),
                .pwdata         (pwdata),
                .prdata         (prdata),
                .pready         (pready),
                .pslverr        (pslverr),
                .sample_valid   (sample_valid),
                .sample_data    (sample_data),
                .sample_channel (sample_channel),
                .enable         (enable),
                .filter_en      (filter_en),
                .filter_clear   (filter_clear),
                .channel        (channel)
        );

endmodule

// ==== verif/tb_adc_model.sv ====
`timescale 1ns/1ns

module tb_adc_model
(
        input  logic                  sys_clk,
        input  logic                  reset,
        input  logic                  cmd_valid,
        input  adc_pkg::adc_channel_t cmd_channel,
        output logic                  cmd_ready,
        output logic                  rsp_valid,
        output adc_pkg::adc_channel_t rsp_channel,
        output adc_pkg::adc_sample_t  rsp_data
);

        import adc_pkg::*;

        logic         accepted;
        logic         busy;
        adc_channel_t held_channel;
        int unsigned  countdown;

        initial
        begin
                cmd_ready   = 1'b0;
                rsp_valid   = 1'b0;
                rsp_channel = '0;
                rsp_data    = '0;
                busy        = 1'b0;
        end

        // handshake seen on the rising edge
        always @(posedge sys_clk)
        begin
                accepted <= !reset && cmd_valid && cmd_ready;
                if (cmd_valid && cmd_ready)
                        held_channel <= cmd_channel;
        end

        always @(negedge sys_clk)
        begin
                rsp_valid = 1'b0;                              // single beat
                if (reset)
                begin
                        cmd_ready = 1'b0;
                        busy      = 1'b0;
                end
                else if (accepted)
                begin
                        cmd_ready = 1'b0;
                        busy      = 1'b1;
                        countdown = 4 + $urandom % 9;          // 4 to 12 cycles
                end
                else if (busy)
                begin
                        countdown--;
                        if (countdown == 0)
                        begin
                                rsp_valid   = 1'b1;
                                rsp_channel = held_channel;
                                rsp_data    = adc_sample_t'($urandom);
                                busy        = 1'b0;
                        end
                end
                else
                        cmd_ready = ($urandom % 4) != 0;      // ready three times in four
        end

endmodule

// ==== verif/tb_adc_subsystem.sv ====
`timescale 1ns/1ns

module tb_adc_subsystem;

        import adc_pkg::*;

        localparam int CLK_PERIOD     = 8;
        localparam int FILTER_DEPTH   = 6;
        localparam int TIMEOUT_CYCLES = 20000;        // 18 conversions need about 1000 cycles
        localparam int POLL_LIMIT     = 200;

        logic         sys_clk;
        logic         reset;
        logic         psel;
        logic         penable;
        logic         pwrite;
        apb_addr_t    paddr;
        apb_data_t    pwdata;
        apb_data_t    prdata;
        logic         pready;
        logic         pslverr;
        logic         sync_trigger;
        logic         cmd_valid;
        adc_channel_t cmd_channel;
        logic         cmd_ready;
        logic         rsp_valid;
        adc_channel_t rsp_channel;
        adc_sample_t  rsp_data;

        adc_sample_t  since_clear[$];                 // responses since the last CTRL write
        logic         filter_mode;
        adc_channel_t cur_channel;
        int           conv_issued    = 0;
        int           rsp_count      = 0;
        int           cmd_count      = 0;
        int           valid_cycles   = 0;
        int           cycle_count    = 0;
        int           mismatch_count = 0;
        int           other_count    = 0;

        event         xfer_done;
        apb_addr_t    xfer_addr;
        apb_data_t    got_data;
        apb_data_t    exp_data;
        logic         got_err;
        logic         got_ready;
        logic         exp_err;
        logic         check_data;

        adc_subsystem #(
                .FILTER_DEPTH (FILTER_DEPTH)
        ) adc_subsystem_inst (
                .sys_clk      (sys_clk),
                .reset        (reset),
                .psel         (psel),
                .penable      (penable),
                .pwrite       (pwrite),
                .paddr        (paddr),
                .pwdata       (pwdata),
                .prdata       (prdata),
                .pready       (pready),
                .pslverr      (pslverr),
                .sync_trigger (sync_trigger),
                .cmd_valid    (cmd_valid),
                .cmd_channel  (cmd_channel),
                .cmd_ready    (cmd_ready),
                .rsp_valid    (rsp_valid),
                .rsp_channel  (rsp_channel),
                .rsp_data     (rsp_data)
        );

        tb_adc_model tb_adc_model_inst (
                .sys_clk     (sys_clk),
                .reset       (reset),
                .cmd_valid   (cmd_valid),
                .cmd_channel (cmd_channel),
                .cmd_ready   (cmd_ready),
                .rsp_valid   (rsp_valid),
                .rsp_channel (rsp_channel),
                .rsp_data    (rsp_data)
        );

        initial
                sys_clk = 1'b0;

        always
                #(CLK_PERIOD/2) sys_clk = ~sys_clk;

        // expected DATA sample, missing history counts as zero
        function automatic adc_sample_t ref_sample(input logic averaging);
                int sum;
                int n;
                sum = 0;
                n   = since_clear.size();
                if (!averaging)
                        return since_clear[n-1];
                for (int i = 0; i < FILTER_DEPTH && i < n; i++)
                        sum += int'(since_clear[n-1-i]);
                return adc_sample_t'(sum / FILTER_DEPTH);     // truncated mean
        endfunction

        always @(posedge sys_clk)
        begin
                cycle_count++;
                if (rsp_valid)
                begin
                        since_clear.push_back(rsp_data);
                        rsp_count++;
                end
                if (cmd_valid)
                        valid_cycles++;
                if (cmd_valid && cmd_ready)
                begin
                        cmd_count++;
                        assert (cmd_channel == cur_channel)
                        else
                        begin
                                mismatch_count++;
                                $display("Mismatch at %0t: command channel %0d, expected %0d",
                                         $time, cmd_channel, cur_channel);
                        end
                end
                if (cycle_count >= TIMEOUT_CYCLES)
                begin
                        $display("Timeout: run stopped after %0d cycles", cycle_count);
                        $display("Test FAILED");
                        $finish;
                end
        end

        always @(xfer_done)
        begin
                assert (got_ready)
                else
                begin
                        mismatch_count++;
                        $display("Mismatch at %0t: pready low at offset 0x%02h",
                                 $time, xfer_addr);
                end
                assert (got_err == exp_err)
                else
                begin
                        mismatch_count++;
                        $display("Mismatch at %0t: pslverr %0b at offset 0x%02h, expected %0b",
                                 $time, got_err, xfer_addr, exp_err);
                end
                if (check_data)
                begin
                        assert (got_data == exp_data)
                        else
                        begin
                                mismatch_count++;
                                $display("Mismatch at %0t: offset 0x%02h read 0x%08h, expected 0x%08h",
                                         $time, xfer_addr, got_data, exp_data);
                        end
                end
        end

        task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata);
                @(negedge sys_clk);
                psel    = 1'b1;
                penable = 1'b0;
                pwrite  = write;
                paddr   = addr;
                pwdata  = wdata;
                @(negedge sys_clk);
                penable = 1'b1;
                #(CLK_PERIOD/4);                              // mid access phase
                got_data  = prdata;
                got_err   = pslverr;
                got_ready = pready;
                xfer_addr = addr;
                @(negedge sys_clk);
                psel    = 1'b0;
                penable = 1'b0;
                pwrite  = 1'b0;
        endtask

        task automatic check_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                                    input logic compare, input apb_data_t expected, input logic err);
                apb_access(write, addr, wdata);
                check_data = compare;
                exp_data   = expected;
                exp_err    = err;
                -> xfer_done;
        endtask

        task automatic write_ctrl(input apb_data_t value);
                check_access(1'b1, REG_CTRL, value, 1'b0, '0, 1'b0);
                filter_mode = value[1];
                cur_channel = value[8:4];
                since_clear.delete();                         // filter history restarts
                check_access(1'b0, REG_CTRL, '0, 1'b1, value & 32'h0000_01f3, 1'b0);
        endtask

        task automatic pulse_trigger();
                @(negedge sys_clk);
                sync_trigger = 1'b1;
                @(negedge sys_clk);
                sync_trigger = 1'b0;
        endtask

        task automatic wait_ready();
                int polls;
                polls    = 0;
                got_data = '0;
                while (!got_data[0] && polls < POLL_LIMIT)
                begin
                        apb_access(1'b0, REG_STATUS, '0);
                        polls++;
                end
                assert (got_data[0])
                else
                begin
                        other_count++;
                        $display("sample_ready did not rise within %0d status reads", POLL_LIMIT);
                end
        endtask

        task automatic wait_responses(input int target);
                int cycles;
                cycles = 0;
                while (rsp_count < target && cycles < POLL_LIMIT)
                begin
                        @(negedge sys_clk);
                        cycles++;
                end
                assert (rsp_count >= target)
                else
                begin
                        other_count++;
                        $display("converter gave %0d responses, %0d were due", rsp_count, target);
                end
                repeat (2)
                        @(negedge sys_clk);                   // filter then registers
        endtask

        task automatic run_conversion();
                pulse_trigger();
                conv_issued++;
                wait_ready();
                check_access(1'b0, REG_DATA, '0, 1'b1,
                             {11'd0, cur_channel, 4'd0, ref_sample(filter_mode)}, 1'b0);
                check_access(1'b0, REG_STATUS, '0, 1'b1, '0, 1'b0);   // ready cleared by DATA read
        endtask

        initial
        begin
                void'($urandom(32'h3a8c_cb16));
                reset        = 1'b1;
                psel         = 1'b0;
                penable      = 1'b0;
                pwrite       = 1'b0;
                paddr        = '0;
                pwdata       = '0;
                sync_trigger = 1'b0;
                filter_mode  = 1'b0;
                cur_channel  = '0;
                repeat (5)
                        @(negedge sys_clk);
                reset = 1'b0;

                // reset values, and a trigger while disabled
                for (int i = 0; i < 4; i++)
                        check_access(1'b0, apb_addr_t'(4 * i), '0, 1'b1, '0, 1'b0);
                pulse_trigger();
                repeat (10)
                        @(negedge sys_clk);
                assert (valid_cycles == 0)
                else
                begin
                        mismatch_count++;
                        $display("Mismatch at %0t: cmd_valid high while disabled", $time);
                end

                write_ctrl(32'h0000_0091);                    // enable, bypass, channel 9
                repeat (3)
                        run_conversion();

                write_ctrl(32'h0000_0153);                    // enable, averaging, channel 21
                repeat (10)
                        run_conversion();
                write_ctrl(32'h0000_0153);
                repeat (3)
                        run_conversion();

                // overrun, with extra triggers while busy
                write_ctrl(32'h0000_0031);
                pulse_trigger();
                conv_issued++;
                pulse_trigger();
                pulse_trigger();
                wait_responses(conv_issued);
                pulse_trigger();
                conv_issued++;
                wait_responses(conv_issued);
                check_access(1'b0, REG_STATUS, '0, 1'b1, 32'h3, 1'b0);
                check_access(1'b0, REG_STATUS, '0, 1'b1, 32'h1, 1'b0);
                check_access(1'b0, REG_DATA, '0, 1'b1,
                             {11'd0, cur_channel, 4'd0, ref_sample(filter_mode)}, 1'b0);
                check_access(1'b0, REG_COUNT, '0, 1'b1, apb_data_t'(conv_issued), 1'b0);
                assert (cmd_count == conv_issued && rsp_count == conv_issued)
                else
                begin
                        mismatch_count++;
                        $display("Mismatch at %0t: %0d commands, %0d responses, expected %0d",
                                 $time, cmd_count, rsp_count, conv_issued);
                end

                // slave errors leave the registers alone
                check_access(1'b0, 8'h10, '0, 1'b0, '0, 1'b1);
                check_access(1'b1, REG_DATA, 32'hffff_ffff, 1'b0, '0, 1'b1);
                check_access(1'b1, REG_STATUS, 32'hffff_ffff, 1'b0, '0, 1'b1);
                check_access(1'b1, REG_COUNT, 32'hffff_ffff, 1'b0, '0, 1'b1);
                check_access(1'b0, REG_STATUS, '0, 1'b1, '0, 1'b0);
                check_access(1'b0, REG_DATA, '0, 1'b1,
                             {11'd0, cur_channel, 4'd0, ref_sample(filter_mode)}, 1'b0);
                check_access(1'b0, REG_COUNT, '0, 1'b1, apb_data_t'(conv_issued), 1'b0);
                check_access(1'b0, REG_CTRL, '0, 1'b1, 32'h0000_0031, 1'b0);

                repeat (2)
                        @(negedge sys_clk);
                $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
                if (mismatch_count == 0 && other_count == 0)
                        $display("Test OK");
                else
                        $display("Test FAILED");
                $finish;
        end

endmodule

// ==== verilog.f ====
source/adc_pkg.sv
source/adc_sequencer.sv
source/adc_average_filter.sv
source/adc_apb_regs.sv
source/adc_subsystem.sv
verif/tb_adc_model.sv
verif/tb_adc_subsystem.sv

// ==== Makefile ====
# Verilator build and run of the ADC subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_adc_subsystem
RTL_TOP   ?= adc_subsystem
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only source/adc_pkg.sv source/adc_sequencer.sv \
		source/adc_average_filter.sv source/adc_apb_regs.sv source/adc_subsystem.sv \
		--top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
